// File: compile.f
sdram_cfg_pkg.sv
mem_port_pkg.sv
req_queue.sv
port_arbiter.sv
refresh_timer.sv
sdram_fsm.sv
latency_delay.sv
sdram_data_path.sv
sdram_ctrl_top.sv
sdram_model.sv
sdram_fsm_props.sv
tb_sdram_ctrl.sv

// File: tb_sdram_ctrl.sv
`timescale 1ns/1ps

module tb_sdram_ctrl;
   import sdram_cfg_pkg::*;
   import mem_port_pkg::*;

   localparam int NUM_ROWS   = 12;
   localparam int PAR_FIRST  = 8;
   localparam int WAIT_LIMIT = 300;

   logic                            sdram_clk;
   logic                            sdram_rst;
   logic [NUM_PORTS-1:0]            req_push;
   logic [NUM_PORTS-1:0]            req_we;
   logic [NUM_PORTS-1:0][ADR_W-1:0] req_adr;
   word_t [NUM_PORTS-1:0]           req_dat;
   be_t [NUM_PORTS-1:0]             req_be;
   logic [NUM_PORTS-1:0]            req_full;
   logic                            rd_valid;
   port_idx_t                       rd_port;
   word_t                           rd_dat;
   logic                            cke;
   logic                            cs_n;
   logic                            ras_n;
   logic                            cas_n;
   logic                            we_n;
   logic [BA_W-1:0]                 ba;
   logic [ROW_W-1:0]                a;
   logic [15:0]                     dq_out;
   logic [1:0]                      dqm;
   logic                            dq_oe;
   logic [15:0]                     dq_in;
   int                              ref_cnt;
   logic                            bad_access;
   logic [15:0]                     lfsr = 16'd5;

   // Table columns are name, port, we, address, data, byte enables, expected read word
   string      row_name [NUM_ROWS] = '{"full_write", "full_readback", "known_word",
      "partial_0101", "partial_0101_readback", "upper_known", "partial_1010",
      "partial_1010_readback", "seed_p0", "seed_p1", "seed_p2", "seed_p3"};
   port_idx_t  row_port [NUM_ROWS] = '{1, 1, 2, 2, 2, 3, 3, 3, 0, 1, 2, 3};
   logic       row_we   [NUM_ROWS] = '{1, 0, 1, 1, 0, 1, 1, 0, 1, 1, 1, 1};
   logic [ADR_W-1:0] row_adr [NUM_ROWS] = '{23'h212345, 23'h212345, 23'h5ABC07,
      23'h5ABC07, 23'h5ABC07, 23'h6F0F80, 23'h6F0F80, 23'h6F0F80, 23'h001001,
      23'h202002, 23'h403003, 23'h7FFFFF};
   word_t      row_dat  [NUM_ROWS] = '{32'hCAFE_0123, 32'h0, 32'h1122_3344,
      32'hAABB_CCDD, 32'h0, 32'h5566_7788, 32'hEEFF_0011, 32'h0, 32'h0A0A_5050,
      32'h1B1B_6161, 32'h2C2C_7272, 32'h3D3D_8383};
   be_t        row_be   [NUM_ROWS] = '{4'hF, 4'hF, 4'hF, 4'b0101, 4'hF, 4'hF,
      4'b1010, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF};
   word_t      row_exp  [NUM_ROWS] = '{32'h0, 32'hCAFE_0123, 32'h0, 32'h0,
      32'h11BB_33DD, 32'h0, 32'h0, 32'hEE66_0088, 32'h0, 32'h0, 32'h0, 32'h0};

   sdram_ctrl_top uut (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .req_push_i (req_push),
      .req_we_i   (req_we),
      .req_adr_i  (req_adr),
      .req_dat_i  (req_dat),
      .req_be_i   (req_be),
      .req_full_o (req_full),
      .rd_valid_o (rd_valid),
      .rd_port_o  (rd_port),
      .rd_dat_o   (rd_dat),
      .cke_o      (cke),
      .cs_n_o     (cs_n),
      .ras_n_o    (ras_n),
      .cas_n_o    (cas_n),
      .we_n_o     (we_n),
      .ba_o       (ba),
      .a_o        (a),
      .dq_o       (dq_out),
      .dqm_o      (dqm),
      .dq_oe_o    (dq_oe),
      .dq_i       (dq_in)
   );

   sdram_model u_model (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .cke_i        (cke),
      .cs_n_i       (cs_n),
      .ras_n_i      (ras_n),
      .cas_n_i      (cas_n),
      .we_n_i       (we_n),
      .ba_i         (ba),
      .a_i          (a),
      .dq_i         (dq_out),
      .dqm_i        (dqm),
      .dq_oe_i      (dq_oe),
      .dq_o         (dq_in),
      .ref_cnt_o    (ref_cnt),
      .bad_access_o (bad_access)
   );

   initial begin
      sdram_clk = 1'b0;
      forever begin
         #20 sdram_clk = ~sdram_clk;
      end
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         fail_now($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         val  = (val << 1) | int'(lfsr[0]);
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic wait_not_full(input port_idx_t p);
      int t;
      t = 0;
      while (req_full[p] && t < WAIT_LIMIT) begin
         @(negedge sdram_clk);
         t++;
      end
      assert (!req_full[p]) else fail_now($sformatf("port %0d queue stayed full", p));
   endtask

   task automatic load_port(input int i);
      req_push[row_port[i]] = 1'b1;
      req_we[row_port[i]]   = row_we[i];
      req_adr[row_port[i]]  = row_adr[i];
      req_dat[row_port[i]]  = row_dat[i];
      req_be[row_port[i]]   = row_be[i];
   endtask

   task automatic send_pushes();
      @(negedge sdram_clk);
      req_push = '0;
   endtask

   task automatic wait_response(input string name, output port_idx_t port,
                                output word_t dat);
      int t;
      t = 0;
      @(negedge sdram_clk);
      while (!rd_valid && t < WAIT_LIMIT) begin
         @(negedge sdram_clk);
         t++;
      end
      assert (rd_valid) else fail_now($sformatf("%s got no read response in time", name));
      port = rd_port;
      dat  = rd_dat;
   endtask

   always @(negedge sdram_clk) begin
      assert (!bad_access) else fail_now("SDRAM model saw an access to a closed bank");
      assert (uut.u_fsm.u_props.fail_cnt == 0)
         else fail_now("command timing assertions on the FSM failed");
   end

   initial begin
      port_idx_t port;
      word_t     dat;
      int        idle;
      int        ref_start;
      sdram_rst = 1'b0;
      req_push  = '0;
      req_we    = '0;
      req_adr   = '0;
      req_dat   = '0;
      req_be    = '0;
      #1;
      sdram_rst = 1'b1;
      #4;
      assert ({ras_n, cas_n, we_n} == 3'b111 && !dq_oe && !rd_valid && !cke && req_full == '0)
         else fail_now("pins not quiet in reset before the first clock");
      repeat (3) @(posedge sdram_clk);
      @(negedge sdram_clk);
      sdram_rst = 1'b0;
      @(negedge sdram_clk);
      assert (cke) else fail_now("cke did not rise after reset");

      for (int i = 0; i < NUM_ROWS; i++) begin
         draw_bits(2, idle);
         repeat (idle) @(negedge sdram_clk);
         wait_not_full(row_port[i]);
         load_port(i);
         send_pushes();
         if (!row_we[i]) begin
            wait_response(row_name[i], port, dat);
            check_value({row_name[i], "_port"}, 32'(row_port[i]), 32'(port));
            check_value(row_name[i], row_exp[i], dat);
         end
      end

      // Answers to a joint push arrive lowest index first
      for (int p = 0; p < NUM_PORTS; p++) begin
         wait_not_full(port_idx_t'(p));
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         load_port(PAR_FIRST + p);
         req_we[p] = 1'b0;
      end
      send_pushes();
      for (int k = 0; k < NUM_PORTS; k++) begin
         wait_response($sformatf("parallel_read_%0d", k), port, dat);
         check_value($sformatf("parallel_read_%0d_port", k), k, 32'(port));
         check_value($sformatf("parallel_read_%0d", k), row_dat[PAR_FIRST + k], dat);
      end

      ref_start = ref_cnt;
      repeat (4 * REF_INTERVAL) @(negedge sdram_clk);
      assert (ref_cnt - ref_start >= 3) else begin
         fail_now($sformatf("ERROR refresh_window: expected at least 3, actual %0d",
                            ref_cnt - ref_start));
      end

      if (uut.u_fsm.u_props.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         fail_now("command timing assertions on the FSM failed");
      end
   end

endmodule

// File: sdram_fsm_props.sv
`timescale 1ns/1ps

module sdram_fsm_props (
   input logic                sdram_clk,
   input logic                sdram_rst,
   input sdram_cfg_pkg::cmd_t cmd_i,
   input logic                wr_beat0_i
);
   import sdram_cfg_pkg::*;

   int fail_cnt = 0;

   // No column command inside tRCD
   rcd_spacing: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_i == CMD_ACTIVE) |=> !(cmd_i inside {CMD_READ, CMD_WRITE}) [*T_RCD])
   else begin
      $error("READ or WRITE issued within tRCD of ACTIVE");
      fail_cnt++;
   end

   // Second write beat keeps the command bus idle
   oe_with_write: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      wr_beat0_i |=> (!wr_beat0_i && cmd_i == CMD_NOP))
   else begin
      $error("write data window overlaps another command");
      fail_cnt++;
   end

   rfc_quiet: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_i == CMD_REFRESH) |=> (cmd_i == CMD_NOP) [*T_RFC])
   else begin
      $error("command issued within tRFC of REFRESH");
      fail_cnt++;
   end

endmodule

bind sdram_fsm sdram_fsm_props u_props (
   .sdram_clk  (sdram_clk),
   .sdram_rst  (sdram_rst),
   .cmd_i      (cmd_o),
   .wr_beat0_i (wr_beat0_o)
);

// File: sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  logic                            cke_i,
   input  logic                            cs_n_i,
   input  logic                            ras_n_i,
   input  logic                            cas_n_i,
   input  logic                            we_n_i,
   input  logic [sdram_cfg_pkg::BA_W-1:0]  ba_i,
   input  logic [sdram_cfg_pkg::ROW_W-1:0] a_i,
   input  logic [15:0]                     dq_i,
   input  logic [1:0]                      dqm_i,
   input  logic                            dq_oe_i,
   output logic [15:0]                     dq_o,
   output int                              ref_cnt_o,
   output logic                            bad_access_o
);
   import sdram_cfg_pkg::*;

   localparam int KEY_W = BA_W + ROW_W + COL_W;
   localparam int BANKS = 1 << BA_W;

   logic [15:0]        mem [logic [KEY_W-1:0]];
   logic               bank_open [BANKS];
   logic [ROW_W-1:0]   open_row [BANKS];
   logic [CAS_LAT-1:0] rd_vld;
   logic [KEY_W-1:0]   rd_key [CAS_LAT];
   logic               wr_next;
   logic [KEY_W-1:0]   wr_key;
   cmd_t               cmd;
   logic [KEY_W-1:0]   key;

   // Unwritten cells return a pattern of their own address
   function automatic logic [15:0] read_beat(input logic [KEY_W-1:0] k);
      if (mem.exists(k)) begin
         return mem[k];
      end
      return 16'(k ^ (k >> 10));
   endfunction

   task automatic write_beat(input logic [KEY_W-1:0] k, input logic [15:0] d,
                             input logic [1:0] m);
      logic [15:0] w;
      w = read_beat(k);
      if (!m[0]) begin
         w[7:0] = d[7:0];
      end
      if (!m[1]) begin
         w[15:8] = d[15:8];
      end
      mem[k] = w;
   endtask

   assign cmd = (!cs_n_i && cke_i) ? cmd_t'({ras_n_i, cas_n_i, we_n_i}) : CMD_NOP;
   assign key = {ba_i, open_row[ba_i], a_i[COL_W-1:0]};

   always @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         rd_vld       <= '0;
         wr_next      <= 1'b0;
         dq_o         <= '0;
         ref_cnt_o    <= 0;
         bad_access_o <= 1'b0;
         for (int b = 0; b < BANKS; b++) begin
            bank_open[b] <= 1'b0;
         end
      end else begin
         rd_vld    <= {rd_vld[CAS_LAT-2:0], cmd == CMD_READ};
         rd_key[0] <= key;
         for (int i = 1; i < CAS_LAT; i++) begin
            rd_key[i] <= rd_key[i-1];
         end
         // Second write beat lands one cycle after WRITE
         wr_next <= (cmd == CMD_WRITE);
         wr_key  <= key + 1'b1;
         if (wr_next && dq_oe_i) begin
            write_beat(wr_key, dq_i, dqm_i);
         end
         case (cmd)
            CMD_ACTIVE: begin
               bank_open[ba_i] <= 1'b1;
               open_row[ba_i]  <= a_i;
            end
            CMD_READ, CMD_WRITE: begin
               if (!bank_open[ba_i]) begin
                  bad_access_o <= 1'b1;
               end
               if (cmd == CMD_WRITE && dq_oe_i) begin
                  write_beat(key, dq_i, dqm_i);
               end
               if (a_i[AP_BIT]) begin
                  bank_open[ba_i] <= 1'b0;
               end
            end
            CMD_PRECHARGE: begin
               for (int b = 0; b < BANKS; b++) begin
                  if (a_i[AP_BIT] || ba_i == BA_W'(b)) begin
                     bank_open[b] <= 1'b0;
                  end
               end
            end
            CMD_REFRESH: begin
               ref_cnt_o <= ref_cnt_o + 1;
            end
            default: begin
            end
         endcase
         // Beats at CAS_LAT and CAS_LAT+1 after READ
         if (rd_vld[CAS_LAT-2]) begin
            dq_o <= read_beat(rd_key[CAS_LAT-2]);
         end else if (rd_vld[CAS_LAT-1]) begin
            dq_o <= read_beat(rd_key[CAS_LAT-1] + 1'b1);
         end else begin
            dq_o <= '0;
         end
      end
   end

endmodule

// File: sdram_ctrl_top.sv
`timescale 1ns/1ps

module sdram_ctrl_top (
   input  logic                                                   sdram_clk,
   input  logic                                                   sdram_rst,
   input  logic [mem_port_pkg::NUM_PORTS-1:0]                     req_push_i,
   input  logic [mem_port_pkg::NUM_PORTS-1:0]                     req_we_i,
   input  logic [mem_port_pkg::NUM_PORTS-1:0][mem_port_pkg::ADR_W-1:0] req_adr_i,
   input  mem_port_pkg::word_t [mem_port_pkg::NUM_PORTS-1:0]      req_dat_i,
   input  mem_port_pkg::be_t [mem_port_pkg::NUM_PORTS-1:0]        req_be_i,
   output logic [mem_port_pkg::NUM_PORTS-1:0]                     req_full_o,
   output logic                                                   rd_valid_o,
   output mem_port_pkg::port_idx_t                                rd_port_o,
   output mem_port_pkg::word_t                                    rd_dat_o,
   output logic                                                   cke_o,
   output logic                                                   cs_n_o,
   output logic                                                   ras_n_o,
   output logic                                                   cas_n_o,
   output logic                                                   we_n_o,
   output logic [sdram_cfg_pkg::BA_W-1:0]                         ba_o,
   output logic [sdram_cfg_pkg::ROW_W-1:0]                        a_o,
   output logic [15:0]                                            dq_o,
   output logic [1:0]                                             dqm_o,
   output logic                                                   dq_oe_o,
   input  logic [15:0]                                            dq_i
);
   import sdram_cfg_pkg::*;
   import mem_port_pkg::*;

   req_t [NUM_PORTS-1:0] heads;
   logic [NUM_PORTS-1:0] empty;
   req_t                 granted;
   port_idx_t            grant_idx;
   logic                 grant_valid;
   logic                 fsm_idle;
   logic                 pop;
   logic                 ref_pending;
   logic                 ref_done;
   logic                 wr_beat0;
   logic                 rd_issue;
   cmd_t                 cmd;

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      req_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
         .sdram_clk (sdram_clk),
         .sdram_rst (sdram_rst),
         .push_i    (req_push_i[p]),
         .entry_i   ({req_we_i[p], req_adr_i[p], req_dat_i[p], req_be_i[p]}),
         .pop_i     (pop && (grant_idx == port_idx_t'(p))),
         .head_o    (heads[p]),
         .empty_o   (empty[p]),
         .full_o    (req_full_o[p])
      );
   end

   assign granted = heads[grant_idx];

   port_arbiter u_arbiter (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .empty_i       (empty),
      .fsm_idle_i    (fsm_idle),
      .grant_idx_o   (grant_idx),
      .grant_valid_o (grant_valid)
   );

   refresh_timer u_refresh (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .ref_done_i    (ref_done),
      .ref_pending_o (ref_pending)
   );

   sdram_fsm u_fsm (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .grant_valid_i (grant_valid),
      .req_we_i      (granted[REQ_WE_BIT]),
      .req_adr_i     (granted[REQ_ADR_LSB +: ADR_W]),
      .ref_pending_i (ref_pending),
      .cmd_o         (cmd),
      .ba_o          (ba_o),
      .a_o           (a_o),
      .pop_o         (pop),
      .ref_done_o    (ref_done),
      .fsm_idle_o    (fsm_idle),
      .wr_beat0_o    (wr_beat0),
      .rd_issue_o    (rd_issue)
   );

   assign {ras_n_o, cas_n_o, we_n_o} = cmd;
   assign cs_n_o = 1'b0;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         cke_o <= 1'b0;
      end else begin
         cke_o <= 1'b1;
      end
   end

   // Requester tag and read strobe follow the data out of the device
   latency_delay #(.DEPTH(CAS_LAT + 2), .payload_t(port_idx_t)) u_tag_dly (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .d_i       (grant_idx),
      .q_o       (rd_port_o)
   );

   latency_delay #(.DEPTH(CAS_LAT + 2), .payload_t(logic)) u_rd_dly (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .d_i       (rd_issue),
      .q_o       (rd_valid_o)
   );

   sdram_data_path u_data_path (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .wr_beat0_i (wr_beat0),
      .wr_dat_i   (granted[REQ_DAT_LSB +: $bits(word_t)]),
      .wr_be_i    (granted[REQ_BE_LSB +: $bits(be_t)]),
      .dq_i       (dq_i),
      .dq_o       (dq_o),
      .dqm_o      (dqm_o),
      .dq_oe_o    (dq_oe_o),
      .rd_word_o  (rd_dat_o)
   );

endmodule

// File: sdram_data_path.sv
`timescale 1ns/1ps

module sdram_data_path (
   input  logic                sdram_clk,
   input  logic                sdram_rst,
   input  logic                wr_beat0_i,
   input  mem_port_pkg::word_t wr_dat_i,
   input  mem_port_pkg::be_t   wr_be_i,
   input  logic [15:0]         dq_i,
   output logic [15:0]         dq_o,
   output logic [1:0]          dqm_o,
   output logic                dq_oe_o,
   output mem_port_pkg::word_t rd_word_o
);

   logic        wr_beat1;
   logic [15:0] hi_dat;
   logic [1:0]  hi_mask;
   logic [15:0] cap_new;
   logic [15:0] cap_old;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_beat1 <= 1'b0;
      end else begin
         wr_beat1 <= wr_beat0_i;
      end
   end

   // High half goes out one cycle after the low half
   always_ff @(posedge sdram_clk) begin
      if (wr_beat0_i) begin
         hi_dat  <= wr_dat_i[31:16];
         hi_mask <= ~wr_be_i[3:2];
      end
   end

   always_comb begin
      if (wr_beat0_i) begin
         dq_o  = wr_dat_i[15:0];
         dqm_o = ~wr_be_i[1:0];
      end else if (wr_beat1) begin
         dq_o  = hi_dat;
         dqm_o = hi_mask;
      end else begin
         dq_o  = '0;
         dqm_o = 2'b00;
      end
   end

   assign dq_oe_o = wr_beat0_i | wr_beat1;

   // First beat ends up in the low half
   always_ff @(posedge sdram_clk) begin
      cap_new <= dq_i;
      cap_old <= cap_new;
   end

   assign rd_word_o = {cap_new, cap_old};

endmodule

// File: latency_delay.sv
`timescale 1ns/1ps

module latency_delay #(
   parameter int  DEPTH     = 1,
   parameter type payload_t = logic
) (
   input  logic     sdram_clk,
   input  logic     sdram_rst,
   input  payload_t d_i,
   output payload_t q_o
);

   payload_t stage [DEPTH];

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= '0;
         end
      end else begin
         stage[0] <= d_i;
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign q_o = stage[DEPTH-1];

endmodule

// File: sdram_fsm.sv
`timescale 1ns/1ps

module sdram_fsm (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  logic                            grant_valid_i,
   input  logic                            req_we_i,
   input  logic [mem_port_pkg::ADR_W-1:0]  req_adr_i,
   input  logic                            ref_pending_i,
   output sdram_cfg_pkg::cmd_t             cmd_o,
   output logic [sdram_cfg_pkg::BA_W-1:0]  ba_o,
   output logic [sdram_cfg_pkg::ROW_W-1:0] a_o,
   output logic                            pop_o,
   output logic                            ref_done_o,
   output logic                            fsm_idle_o,
   output logic                            wr_beat0_o,
   output logic                            rd_issue_o
);
   import sdram_cfg_pkg::*;
   import mem_port_pkg::*;

   typedef enum logic [2:0] {
      INIT_PRE,
      INIT_MODE,
      IDLE,
      ACTIVATE,
      ACCESS,
      REFRESH,
      WAIT
   } state_t;

   state_t            state;
   state_t            state_nx;
   state_t            ret_state;
   state_t            ret_nx;
   logic [WAIT_W-1:0] wait_cnt;
   logic [WAIT_W-1:0] wait_nx;
   logic [BA_W-1:0]   bank;
   logic [ROW_W-1:0]  row;
   logic [ROW_W-1:0]  col_ap;
   logic [ROW_W-1:0]  all_banks;

   // Column LSB is zero, a word is two beats
   always_comb begin
      bank              = req_adr_i[ADR_W-1 -: BA_W];
      row               = req_adr_i[ADR_W-BA_W-1 -: ROW_W];
      col_ap            = '0;
      col_ap[COL_W-1:0] = {req_adr_i[COL_W-2:0], 1'b0};
      col_ap[AP_BIT]    = 1'b1;
      all_banks         = '0;
      all_banks[AP_BIT] = 1'b1;
   end

   always_comb begin
      state_nx = state;
      ret_nx   = ret_state;
      wait_nx  = wait_cnt;
      case (state)
         INIT_PRE: begin
            state_nx = WAIT;
            ret_nx   = INIT_MODE;
            wait_nx  = WAIT_W'(T_RP);
         end
         INIT_MODE: begin
            state_nx = WAIT;
            ret_nx   = IDLE;
            wait_nx  = WAIT_W'(T_RP);
         end
         IDLE: begin
            // Refresh outranks port traffic
            if (ref_pending_i) begin
               state_nx = REFRESH;
            end else if (grant_valid_i) begin
               state_nx = ACTIVATE;
            end
         end
         ACTIVATE: begin
            state_nx = WAIT;
            ret_nx   = ACCESS;
            wait_nx  = WAIT_W'(T_RCD);
         end
         ACCESS: begin
            state_nx = WAIT;
            ret_nx   = IDLE;
            wait_nx  = WAIT_W'(T_WR_DONE);
         end
         REFRESH: begin
            state_nx = WAIT;
            ret_nx   = IDLE;
            wait_nx  = WAIT_W'(T_RFC);
         end
         WAIT: begin
            if (wait_cnt == WAIT_W'(1)) begin
               state_nx = ret_state;
            end else begin
               wait_nx = wait_cnt - 1'b1;
            end
         end
         default: begin
            state_nx = IDLE;
         end
      endcase
   end

   // Arbiter may resample only while no grant is being taken
   assign fsm_idle_o = (state == IDLE && !grant_valid_i) || (state == WAIT && ret_state == IDLE);

   // Pins follow the state that is entered
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state      <= WAIT;
         ret_state  <= INIT_PRE;
         wait_cnt   <= WAIT_W'(T_RP);
         cmd_o      <= CMD_NOP;
         ba_o       <= '0;
         a_o        <= '0;
         pop_o      <= 1'b0;
         ref_done_o <= 1'b0;
         wr_beat0_o <= 1'b0;
         rd_issue_o <= 1'b0;
      end else begin
         state      <= state_nx;
         ret_state  <= ret_nx;
         wait_cnt   <= wait_nx;
         pop_o      <= 1'b0;
         ref_done_o <= 1'b0;
         wr_beat0_o <= 1'b0;
         rd_issue_o <= 1'b0;
         case (state_nx)
            INIT_PRE: begin
               cmd_o <= CMD_PRECHARGE;
               a_o   <= all_banks;
            end
            INIT_MODE: begin
               cmd_o <= CMD_LOAD_MODE;
               ba_o  <= '0;
               a_o   <= MODE_WORD;
            end
            ACTIVATE: begin
               cmd_o <= CMD_ACTIVE;
               ba_o  <= bank;
               a_o   <= row;
            end
            ACCESS: begin
               cmd_o      <= req_we_i ? CMD_WRITE : CMD_READ;
               ba_o       <= bank;
               a_o        <= col_ap;
               pop_o      <= 1'b1;
               wr_beat0_o <= req_we_i;
               rd_issue_o <= !req_we_i;
            end
            REFRESH: begin
               cmd_o      <= CMD_REFRESH;
               ref_done_o <= 1'b1;
            end
            default: begin
               cmd_o <= CMD_NOP;
            end
         endcase
      end
   end

endmodule

// File: refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer (
   input  logic sdram_clk,
   input  logic sdram_rst,
   input  logic ref_done_i,
   output logic ref_pending_o
);
   import sdram_cfg_pkg::*;

   logic [REF_CNT_W-1:0] ref_cnt;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt       <= REF_CNT_W'(REF_INTERVAL - 1);
         ref_pending_o <= 1'b0;
      end else begin
         if (ref_cnt == '0) begin
            ref_cnt <= REF_CNT_W'(REF_INTERVAL - 1);
         end else begin
            ref_cnt <= ref_cnt - 1'b1;
         end
         // New request wins over a clear in the same cycle
         if (ref_cnt == '0) begin
            ref_pending_o <= 1'b1;
         end else if (ref_done_i) begin
            ref_pending_o <= 1'b0;
         end
      end
   end

endmodule

// File: port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter (
   input  logic                               sdram_clk,
   input  logic                               sdram_rst,
   input  logic [mem_port_pkg::NUM_PORTS-1:0] empty_i,
   input  logic                               fsm_idle_i,
   output mem_port_pkg::port_idx_t            grant_idx_o,
   output logic                               grant_valid_o
);
   import mem_port_pkg::*;

   port_idx_t pick;
   logic      any_req;

   // Scan downwards so the lowest non-empty index is kept
   always_comb begin
      pick    = '0;
      any_req = 1'b0;
      for (int i = NUM_PORTS - 1; i >= 0; i--) begin
         if (!empty_i[i]) begin
            pick    = port_idx_t'(i);
            any_req = 1'b1;
         end
      end
   end

   // Grant frozen while a request is in service
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         grant_idx_o   <= '0;
         grant_valid_o <= 1'b0;
      end else if (fsm_idle_i) begin
         grant_idx_o   <= pick;
         grant_valid_o <= any_req;
      end
   end

endmodule

// File: req_queue.sv
`timescale 1ns/1ps

module req_queue #(
   parameter int DEPTH = mem_port_pkg::QUEUE_DEPTH
) (
   input  logic               sdram_clk,
   input  logic               sdram_rst,
   input  logic               push_i,
   input  mem_port_pkg::req_t entry_i,
   input  logic               pop_i,
   output mem_port_pkg::req_t head_o,
   output logic               empty_o,
   output logic               full_o
);
   import mem_port_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   req_t             mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count == '0);
   assign full_o  = (count == CNT_W'(DEPTH));
   // Push at full is dropped
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   always_ff @(posedge sdram_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= entry_i;
      end
   end

endmodule

// File: mem_port_pkg.sv
package mem_port_pkg;

   localparam int NUM_PORTS = 4;
   typedef logic [1:0] port_idx_t;

   // Bank, row and upper column bits
   localparam int ADR_W = 23;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  be_t;

   // Request word {we, adr, dat, be}
   localparam int REQ_BE_LSB  = 0;
   localparam int REQ_DAT_LSB = REQ_BE_LSB + $bits(be_t);
   localparam int REQ_ADR_LSB = REQ_DAT_LSB + $bits(word_t);
   localparam int REQ_WE_BIT  = REQ_ADR_LSB + ADR_W;
   localparam int REQ_W       = REQ_WE_BIT + 1;

   typedef logic [REQ_W-1:0] req_t;

   localparam int QUEUE_DEPTH = 4;

endpackage

// File: sdram_cfg_pkg.sv
package sdram_cfg_pkg;

   // Device geometry
   localparam int BA_W  = 2;
   localparam int ROW_W = 13;
   localparam int COL_W = 9;

   localparam int CAS_LAT = 2;

   // Wait counts in cycles
   localparam int T_RP      = 2;
   localparam int T_RCD     = 2;
   localparam int T_RFC     = 7;
   localparam int T_WR_DONE = 4;
   localparam int WAIT_W    = 3;

   // Short refresh interval for simulation
   localparam int REF_INTERVAL = 150;
   localparam int REF_CNT_W    = 8;

   localparam int AP_BIT = 10;

   // Burst length 2, sequential, CAS latency in bits 6:4
   localparam logic [ROW_W-1:0] MODE_WORD = {6'b000000, 3'(CAS_LAT), 1'b0, 3'b001};

   // Encoded as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_LOAD_MODE = 3'b000,
      CMD_REFRESH   = 3'b001,
      CMD_PRECHARGE = 3'b010,
      CMD_ACTIVE    = 3'b011,
      CMD_WRITE     = 3'b100,
      CMD_READ      = 3'b101,
      CMD_NOP       = 3'b111
   } cmd_t;

endpackage
